//--- common/audio_pkg.sv
// Audio path types
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

        typedef logic [`AUD_SAMPLE_W-1:0] sample_t;
        typedef logic [`AUD_ADDR_W-1:0] addr_t;

        // One write into the sample memory, valid for a single cycle when en is set
        typedef struct packed {
                logic    en;
                addr_t   addr;
                sample_t data;
        } sram_wr_t;

        // Recorder control, each field a one-cycle pulse
        typedef struct packed {
                logic start;
                logic pause;
                logic stop;
        } rec_ctrl_t;

endpackage

`default_nettype wire

//--- common/audio_settings.svh
// Audio path sizing
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Width of one PCM sample word
`define AUD_SAMPLE_W 16

// Sample memory address width and depth in words
`define AUD_ADDR_W 10
`define AUD_MEM_DEPTH 1024

`endif

//--- design/audio_subsys.sv
// Audio record and playback top
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module audio_subsys import audio_pkg::*; (
        input  logic      i_clk,
        input  logic      i_rst_n,
        input  logic      i_lrc,
        input  logic      i_adcdat,
        input  rec_ctrl_t i_rec_ctrl,
        input  logic      i_play,
        input  logic      i_play_stop,
        output logic      o_dacdat,
        output logic      o_playing,
        output logic      o_recording,
        output addr_t     o_rec_len
);

        sram_wr_t rec_wr;
        addr_t    rd_addr;
        sample_t  rd_data;

        i2s_recorder u_recorder (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_lrc       (i_lrc),
                .i_adcdat    (i_adcdat),
                .i_rec_ctrl  (i_rec_ctrl),
                .o_wr        (rec_wr),
                .o_rec_len   (o_rec_len),
                .o_recording (o_recording)
        );

        sample_sram u_sram (
                .i_clk     (i_clk),
                .i_wr      (rec_wr),
                .i_rd_addr (rd_addr),
                .o_rd_data (rd_data)
        );

        // Player reads back the take length that the recorder reports
        i2s_player u_player (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_lrc       (i_lrc),
                .i_play      (i_play),
                .i_play_stop (i_play_stop),
                .i_rec_len   (o_rec_len),
                .i_rd_data   (rd_data),
                .o_rd_addr   (rd_addr),
                .o_dacdat    (o_dacdat),
                .o_playing   (o_playing)
        );

endmodule

`default_nettype wire

//--- design/sample_sram.sv
// Recorded sample memory
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module sample_sram import audio_pkg::*; (
        input  logic     i_clk,
        input  sram_wr_t i_wr,
        input  addr_t    i_rd_addr,
        output sample_t  o_rd_data
);

        sample_t mem [`AUD_MEM_DEPTH];

        // Read and write share the edge, so a colliding read sees the old word
        always_ff @(posedge i_clk) begin
                if (i_wr.en) begin
                        mem[i_wr.addr] <= i_wr.data;
                end
                o_rd_data <= mem[i_rd_addr];
        end

        a_wr_addr_range: assert property (@(posedge i_clk)
                i_wr.en |-> (i_wr.addr < `AUD_MEM_DEPTH))
                else $error("memory write address %0d out of range", i_wr.addr);

endmodule

`default_nettype wire

//--- player/i2s_player.sv
// I2S left-channel player
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module i2s_player import audio_pkg::*; (
        input  logic    i_clk,
        input  logic    i_rst_n,
        input  logic    i_lrc,
        input  logic    i_play,
        input  logic    i_play_stop,
        input  addr_t   i_rec_len,
        input  sample_t i_rd_data,
        output addr_t   o_rd_addr,
        output logic    o_dacdat,
        output logic    o_playing
);

        localparam int unsigned CNT_W = $clog2(`AUD_SAMPLE_W);
        localparam logic [CNT_W-1:0] LAST_SHIFT = CNT_W'(`AUD_SAMPLE_W - 2);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_WAIT,
                ST_SHIFT,
                ST_NEXT
        } play_state_e;

        play_state_e      state;
        logic             lrc_q;
        logic             lrc_fall;
        logic [CNT_W-1:0] bit_cnt;
        sample_t          shift_q;
        addr_t            rd_addr;
        logic             stop_req;
        logic             last_word;
        logic             dac_q;

        assign lrc_fall  = lrc_q & ~i_lrc;
        assign last_word = (rd_addr == i_rec_len - 1'b1);

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        state    <= ST_IDLE;
                        lrc_q    <= 1'b0;
                        bit_cnt  <= '0;
                        rd_addr  <= '0;
                        stop_req <= 1'b0;
                        dac_q    <= 1'b0;
                end else begin
                        lrc_q <= i_lrc;
                        if (state != ST_IDLE && i_play_stop) begin
                                stop_req <= 1'b1; // Honoured at the next frame start
                        end
                        case (state)
                        ST_IDLE: begin
                                // An empty take gives nothing to play
                                if (i_play && i_rec_len != '0) begin
                                        rd_addr  <= '0;
                                        stop_req <= 1'b0;
                                        state    <= ST_WAIT;
                                end
                        end
                        ST_WAIT: begin
                                if (lrc_fall) begin
                                        if (stop_req || i_play_stop) begin
                                                state <= ST_IDLE;
                                        end else begin
                                                dac_q   <= i_rd_data[`AUD_SAMPLE_W-1];
                                                bit_cnt <= '0;
                                                state   <= ST_SHIFT;
                                        end
                                end
                        end
                        ST_SHIFT: begin
                                dac_q   <= shift_q[`AUD_SAMPLE_W-1];
                                bit_cnt <= bit_cnt + 1'b1;
                                if (bit_cnt == LAST_SHIFT) begin
                                        state <= ST_NEXT;
                                end
                        end
                        ST_NEXT: begin
                                dac_q <= 1'b0; // Right half stays silent
                                if (last_word) begin
                                        state <= ST_IDLE;
                                end else begin
                                        rd_addr <= rd_addr + 1'b1; // Prefetch for next frame
                                        state   <= ST_WAIT;
                                end
                        end
                        default: state <= ST_IDLE;
                        endcase
                end
        end

        always_ff @(posedge i_clk) begin
                if (state == ST_WAIT && lrc_fall) begin
                        shift_q <= {i_rd_data[`AUD_SAMPLE_W-2:0], 1'b0};
                end else if (state == ST_SHIFT) begin
                        shift_q <= {shift_q[`AUD_SAMPLE_W-2:0], 1'b0};
                end
        end

        assign o_rd_addr = rd_addr;
        assign o_dacdat  = dac_q;
        assign o_playing = (state != ST_IDLE);

        a_quiet_when_idle: assert property (@(posedge i_clk) disable iff (i_rst_n)
                !o_playing |-> !o_dacdat)
                else $error("DAC data driven while not playing");

endmodule

`default_nettype wire

//--- recorder/i2s_recorder.sv
// I2S left-channel recorder
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module i2s_recorder import audio_pkg::*; (
        input  logic      i_clk,
        input  logic      i_rst_n,
        input  logic      i_lrc,
        input  logic      i_adcdat,
        input  rec_ctrl_t i_rec_ctrl,
        output sram_wr_t  o_wr,
        output addr_t     o_rec_len,
        output logic      o_recording
);

        localparam int unsigned CNT_W = $clog2(`AUD_SAMPLE_W);
        localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`AUD_SAMPLE_W - 1);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_WAIT,
                ST_SHIFT,
                ST_COMMIT
        } rec_state_e;

        rec_state_e       state;
        logic             lrc_q;
        logic             lrc_fall;
        logic [CNT_W-1:0] bit_cnt;
        sample_t          shift_q;
        addr_t            wr_addr;
        logic             paused;
        logic             pause_req;
        logic             stop_req;
        logic             pause_hit;
        logic             stop_hit;

        assign lrc_fall  = lrc_q & ~i_lrc; // Left half begins
        assign pause_hit = pause_req | i_rec_ctrl.pause;
        assign stop_hit  = stop_req | i_rec_ctrl.stop;

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        state     <= ST_IDLE;
                        lrc_q     <= 1'b0;
                        bit_cnt   <= '0;
                        wr_addr   <= '0;
                        paused    <= 1'b0;
                        pause_req <= 1'b0;
                        stop_req  <= 1'b0;
                end else begin
                        lrc_q <= i_lrc;
                        case (state)
                        ST_IDLE: begin
                                if (i_rec_ctrl.start) begin
                                        if (!paused) begin
                                                wr_addr <= '0; // Fresh take
                                        end
                                        paused    <= 1'b0;
                                        pause_req <= 1'b0;
                                        stop_req  <= 1'b0;
                                        state     <= ST_WAIT;
                                end else if (i_rec_ctrl.stop) begin
                                        paused <= 1'b0; // Stop while paused ends the take
                                end
                        end
                        ST_WAIT: begin
                                // No sample in flight, so a pending halt applies at once
                                if (pause_hit || stop_hit) begin
                                        paused    <= ~stop_hit;
                                        pause_req <= 1'b0;
                                        stop_req  <= 1'b0;
                                        state     <= ST_IDLE;
                                end else if (lrc_fall) begin
                                        bit_cnt <= '0;
                                        state   <= ST_SHIFT;
                                end
                        end
                        ST_SHIFT: begin
                                pause_req <= pause_hit; // Held until the sample is written
                                stop_req  <= stop_hit;
                                bit_cnt   <= bit_cnt + 1'b1;
                                if (bit_cnt == LAST_BIT) begin
                                        state <= ST_COMMIT;
                                end
                        end
                        ST_COMMIT: begin
                                wr_addr <= wr_addr + 1'b1;
                                if (pause_hit || stop_hit) begin
                                        paused    <= ~stop_hit;
                                        pause_req <= 1'b0;
                                        stop_req  <= 1'b0;
                                        state     <= ST_IDLE;
                                end else begin
                                        state <= ST_WAIT;
                                end
                        end
                        default: state <= ST_IDLE;
                        endcase
                end
        end

        always_ff @(posedge i_clk) begin
                if (state == ST_SHIFT) begin
                        shift_q <= {shift_q[`AUD_SAMPLE_W-2:0], i_adcdat}; // MSB first
                end
        end

        assign o_wr.en      = (state == ST_COMMIT);
        assign o_wr.addr    = wr_addr;
        assign o_wr.data    = shift_q;
        assign o_rec_len    = wr_addr; // Next free address equals words written
        assign o_recording  = (state != ST_IDLE);

        a_wr_in_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
                o_wr.en |-> (o_wr.addr < `AUD_MEM_DEPTH))
                else $error("recorder write address %0d out of range", o_wr.addr);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile and run the audio subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_audio_subsys \
        -f sim.f

out=$(./obj_dir/Vtb_audio_subsys)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
        exit 0
fi
exit 1

//--- sim.f
+incdir+common
common/audio_pkg.sv
recorder/i2s_recorder.sv
design/sample_sram.sv
player/i2s_player.sv
design/audio_subsys.sv
verif/tb_audio_subsys.sv

//--- verif/tb_audio_subsys.sv
// Audio subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "audio_settings.svh"

module tb_audio_subsys import audio_pkg::*; ();

        localparam int CLK_PERIOD = 100;
        localparam int FRAME_CLKS = 32;

        // Stimulus kinds applied in the middle of a frame's right half
        localparam int P_NONE      = 0;
        localparam int P_START     = 1;
        localparam int P_PAUSE     = 2;
        localparam int P_STOP      = 3;
        localparam int P_PLAY      = 4;
        localparam int P_PLAY_STOP = 5;

        localparam int REC1_FRAMES = 20;
        localparam int PAUSE_A     = 6;
        localparam int PAUSE_GAP   = 5;
        localparam int PAUSE_B     = 10;
        localparam int REC3_FRAMES = 8;
        localparam int STOP_AT     = 4;

        localparam int TOTAL_FRAMES = 1 + (1 + REC1_FRAMES) + (REC1_FRAMES + 2)
                + (1 + PAUSE_A + PAUSE_GAP + PAUSE_B) + (PAUSE_A + PAUSE_B + 2)
                + (1 + REC3_FRAMES) + (REC3_FRAMES + 2) + (STOP_AT + 2);
        localparam int WATCHDOG_NS = (TOTAL_FRAMES * FRAME_CLKS + 64) * CLK_PERIOD;

        logic      i_clk;
        logic      i_rst_n;
        logic      i_lrc;
        logic      i_adcdat;
        rec_ctrl_t i_rec_ctrl;
        logic      i_play;
        logic      i_play_stop;
        logic      o_dacdat;
        logic      o_playing;
        logic      o_recording;
        addr_t     o_rec_len;

        logic [31:0] rng_state;
        logic        right_carry; // Right LSB spills into the next frame's first slot
        logic        model_rec;
        logic        model_paused;
        sample_t     exp_q[$];
        sample_t     rx_q[$];
        int          test_errs;
        int          pass_cnt;
        int          fail_cnt;

        audio_subsys u_dut (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_lrc       (i_lrc),
                .i_adcdat    (i_adcdat),
                .i_rec_ctrl  (i_rec_ctrl),
                .i_play      (i_play),
                .i_play_stop (i_play_stop),
                .o_dacdat    (o_dacdat),
                .o_playing   (o_playing),
                .o_recording (o_recording),
                .o_rec_len   (o_rec_len)
        );

        always #(CLK_PERIOD / 2) i_clk = ~i_clk;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic sample_t rand_sample();
                rng_state = xorshift32(rng_state);
                return rng_state[`AUD_SAMPLE_W-1:0];
        endfunction

        task automatic check_val(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
                assert (got === exp) else begin
                        $display("mismatch %s exp %h got %h", name, exp, got);
                        test_errs++;
                end
        endtask

        task automatic end_test(input string name);
                if (test_errs == 0) begin
                        pass_cnt++;
                        $display("test %s ok", name);
                end else begin
                        fail_cnt++;
                        $display("test %s failed with %0d errors", name, test_errs);
                end
                test_errs = 0;
        endtask

        // One I2S frame in, one DAC frame decoded, with an optional pulse at slot 24
        task automatic run_frame(input sample_t left, input sample_t right, input int pulse);
                logic    din;
                sample_t word;
                logic    msb_playing;
                word        = '0;
                msb_playing = 1'b0;
                if (model_rec) begin
                        exp_q.push_back(left);
                end
                for (int s = 0; s < FRAME_CLKS; s++) begin
                        @(posedge i_clk);
                        #1;
                        if (s == 0) begin
                                din = right_carry;
                        end else if (s <= 16) begin
                                din = left[16-s]; // MSB one slot after the falling edge
                        end else begin
                                din = right[32-s];
                        end
                        i_lrc       = (s >= 16);
                        i_adcdat    = din;
                        i_rec_ctrl  = '0;
                        i_play      = 1'b0;
                        i_play_stop = 1'b0;
                        if (s == 24) begin
                                case (pulse)
                                P_START: begin
                                        if (!model_paused) begin
                                                exp_q.delete(); // Fresh take from address zero
                                        end
                                        model_rec        = 1'b1;
                                        model_paused     = 1'b0;
                                        i_rec_ctrl.start = 1'b1;
                                end
                                P_PAUSE: begin
                                        model_rec        = 1'b0;
                                        model_paused     = 1'b1;
                                        i_rec_ctrl.pause = 1'b1;
                                end
                                P_STOP: begin
                                        model_rec       = 1'b0;
                                        model_paused    = 1'b0;
                                        i_rec_ctrl.stop = 1'b1;
                                end
                                P_PLAY:      i_play = 1'b1;
                                P_PLAY_STOP: i_play_stop = 1'b1;
                                default: ;
                                endcase
                        end
                        if (s >= 1 && s <= 16) begin
                                if (s == 1) begin
                                        msb_playing = o_playing;
                                end
                                word = {word[`AUD_SAMPLE_W-2:0], o_dacdat};
                        end else begin
                                check_val("o_dacdat", 32'd0, {31'd0, o_dacdat});
                        end
                end
                right_carry = right[0];
                if (msb_playing) begin
                        rx_q.push_back(word);
                end
        endtask

        task automatic record_frames(input int n, input int last_pulse);
                for (int i = 0; i < n; i++) begin
                        run_frame(rand_sample(), rand_sample(), (i == n - 1) ? last_pulse : P_NONE);
                end
        endtask

        // Plays the take, or stops it after stop_after words when that is nonzero
        task automatic play_take(input int stop_after);
                int n_words;
                int pulse;
                n_words = (stop_after > 0) ? stop_after : exp_q.size();
                rx_q.delete();
                run_frame(rand_sample(), rand_sample(), P_PLAY);
                for (int i = 0; i < n_words; i++) begin
                        pulse = (stop_after > 0 && i == n_words - 1) ? P_PLAY_STOP : P_NONE;
                        run_frame(rand_sample(), rand_sample(), pulse);
                end
                run_frame(rand_sample(), rand_sample(), P_NONE);
                check_val("o_playing", 32'd0, {31'd0, o_playing});
                check_val("rx_count", n_words, rx_q.size());
                for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
                        check_val("dac_word", {16'd0, exp_q[i]}, {16'd0, rx_q[i]});
                end
        endtask

        initial begin : watchdog
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns with the tests still running",
                         WATCHDOG_NS);
                $display("SIMULATION FAILED");
                $finish;
        end

        initial begin
                i_clk        = 1'b0;
                i_rst_n      = 1'b1;
                i_lrc        = 1'b1;
                i_adcdat     = 1'b0;
                i_rec_ctrl   = '0;
                i_play       = 1'b0;
                i_play_stop  = 1'b0;
                rng_state    = 32'd70;
                right_carry  = 1'b0;
                model_rec    = 1'b0;
                model_paused = 1'b0;
                test_errs    = 0;
                pass_cnt     = 0;
                fail_cnt     = 0;
                repeat (2) @(posedge i_clk);
                #1;
                i_rst_n = 1'b0;

                check_val("o_recording", 32'd0, {31'd0, o_recording});
                check_val("o_playing", 32'd0, {31'd0, o_playing});
                check_val("o_dacdat", 32'd0, {31'd0, o_dacdat});
                check_val("o_rec_len", 32'd0, {22'd0, o_rec_len});
                run_frame(rand_sample(), rand_sample(), P_NONE);
                end_test("reset_state");

                run_frame(rand_sample(), rand_sample(), P_START);
                record_frames(REC1_FRAMES, P_STOP);
                check_val("o_rec_len", REC1_FRAMES, {22'd0, o_rec_len});
                check_val("o_recording", 32'd0, {31'd0, o_recording});
                end_test("record_take");

                play_take(0);
                end_test("play_take");

                run_frame(rand_sample(), rand_sample(), P_START);
                record_frames(PAUSE_A, P_PAUSE);
                check_val("o_recording", 32'd0, {31'd0, o_recording});
                record_frames(PAUSE_GAP, P_START); // Resume keeps the address
                record_frames(PAUSE_B, P_STOP);
                check_val("o_rec_len", PAUSE_A + PAUSE_B, {22'd0, o_rec_len});
                play_take(0);
                end_test("pause_resume");

                run_frame(rand_sample(), rand_sample(), P_START);
                record_frames(REC3_FRAMES, P_STOP);
                check_val("o_rec_len", REC3_FRAMES, {22'd0, o_rec_len});
                play_take(0);
                end_test("restart_take");

                play_take(STOP_AT);
                end_test("play_stop");

                $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire
